// ==== bus_core.f ====
bus_core_pkg.sv
bus_timing.sv
wb_ram_bridge.sv
register_file.sv
address_decoder.sv
bus_core.sv
bus_core_checker.sv
bus_core_assertions.sv
bus_core_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = bus_core_tb
FILELIST   = bus_core.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bus_core_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top with clock, reset, CPU and RAM models, stimulus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bus_core_tb;
    import bus_core_pkg::*;

    localparam int unsigned SLOT_CYCLES    = 4;
    localparam int unsigned CLOCK_PERIOD   = 100;
    localparam int unsigned DRIVE_DELAY    = 10;
    localparam int unsigned RAM_WORDS      = 1 << RAM_ADDR_WIDTH;
    // 2000 CPU slots of a full period each plus margin
    localparam int unsigned TIMEOUT_CYCLES = 2000 * 2 * SLOT_CYCLES + 1000;

    logic        sys_clock;
    logic        sys_reset_n;
    cpu_addr_t   cpu_addr;
    logic        cpu_we;
    data_t       cpu_data;          // Data the CPU model drives on writes
    logic        cpu_be;
    logic        cpu_clock;
    logic        cpu_ready;
    logic        cpu_reset;
    logic        cpu_be_prev;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    data_t       ram_data_in;
    ram_addr_t   ram_addr;
    data_t       ram_data_out;
    logic        ram_data_oe;
    logic        ram_oe;
    logic        ram_we;
    logic        io_oe;
    logic        pia1_cs;
    logic        pia2_cs;
    logic        via_cs;
    data_t       ram [0:RAM_WORDS-1];
    integer      seed;
    integer      cpu_seed;
    int unsigned cycle_count;
    wb_addr_t    addr_list[$];

    bus_core #(
        .SLOT_CYCLES(SLOT_CYCLES)
    ) dut (
        .sys_clock_i  (sys_clock),
        .sys_reset_ni (sys_reset_n),
        .cpu_addr_i   (cpu_addr),
        .cpu_we_i     (cpu_we),
        .cpu_be_o     (cpu_be),
        .cpu_clock_o  (cpu_clock),
        .cpu_ready_o  (cpu_ready),
        .cpu_reset_o  (cpu_reset),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .ram_data_i   (ram_data_in),
        .ram_addr_o   (ram_addr),
        .ram_data_o   (ram_data_out),
        .ram_data_oe_o(ram_data_oe),
        .ram_oe_o     (ram_oe),
        .ram_we_o     (ram_we),
        .io_oe_o      (io_oe),
        .pia1_cs_o    (pia1_cs),
        .pia2_cs_o    (pia2_cs),
        .via_cs_o     (via_cs)
    );

    bus_core_checker #(
        .SLOT_CYCLES(SLOT_CYCLES)
    ) scoreboard (
        .sys_clock_i (sys_clock),
        .sys_reset_ni(sys_reset_n),
        .cpu_addr_i  (cpu_addr),
        .cpu_we_i    (cpu_we),
        .cpu_data_i  (cpu_data),
        .cpu_be_i    (cpu_be),
        .cpu_clock_i (cpu_clock),
        .cpu_ready_i (cpu_ready),
        .cpu_reset_i (cpu_reset),
        .wb_req_i    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .ram_data_i  (ram_data_in),
        .ram_oe_i    (ram_oe),
        .ram_we_i    (ram_we),
        .io_oe_i     (io_oe),
        .pia1_cs_i   (pia1_cs),
        .pia2_cs_i   (pia2_cs),
        .via_cs_i    (via_cs)
    );

    function automatic data_t fill_byte(input ram_addr_t a);
        return a[7:0] ^ a[15:8] ^ {7'h2d, a[16]};
    endfunction

    // RAM model reads while OE is high and writes on the WE pulse
    assign ram_data_in = ram_oe ? ram[ram_addr] : '0;

    always @(posedge sys_clock) begin
        if (ram_we) begin
            ram[ram_addr] <= ram_data_oe ? ram_data_out : cpu_data;
        end
    end

    initial begin
        sys_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) sys_clock = ~sys_clock;
    end

    // CPU model picks a new cycle at the start of each CPU slot
    always @(posedge sys_clock) begin
        logic [31:0] r;
        #DRIVE_DELAY;
        if (cpu_be && !cpu_be_prev) begin
            r = $random(cpu_seed);
            case (r[1:0])
                2'd0:    cpu_addr = {8'hE8, r[15:8]};  // I/O page
                2'd1,
                2'd2:    cpu_addr = {8'h04, r[15:8]};  // Window shared with the host
                default: cpu_addr = r[31:16];
            endcase
            cpu_we   = r[2];
            cpu_data = r[23:16];
        end
        cpu_be_prev = cpu_be;
    end

    // One Wishbone access that holds the request until it is accepted
    task automatic wb_access(input wb_addr_t addr, input logic we, input data_t data);
        int unsigned idle;
        logic        accepted;
        idle = $random(seed) & 7;
        repeat (idle) @(posedge sys_clock);
        #DRIVE_DELAY;
        wb_req   = '{addr: addr, data: data, we: we, cycle: 1'b1, strobe: 1'b1};
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge sys_clock);
            accepted = !wb_rsp.stall;
        end
        #DRIVE_DELAY;
        wb_req.cycle  = 1'b0;
        wb_req.strobe = 1'b0;
        do @(posedge sys_clock); while (!wb_rsp.ack);
    endtask

    initial begin
        wb_addr_t a;
        seed        = 32'he97d_cd7a;
        cpu_seed    = seed ^ 32'h1357_9bdf;
        sys_reset_n = 1'b0;
        cpu_addr    = '0;
        cpu_we      = 1'b0;
        cpu_data    = '0;
        cpu_be_prev = 1'b0;
        wb_req      = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = fill_byte(ram_addr_t'(i));
        end
        repeat (5) @(posedge sys_clock);
        #DRIVE_DELAY;
        sys_reset_n = 1'b1;

        // Read the control register reset value and release the CPU
        wb_access({1'b1, 17'h0}, 1'b0, '0);
        wb_access({1'b1, 17'h0}, 1'b1, 8'h01);
        wb_access({1'b1, 17'h0}, 1'b0, '0);

        // Random RAM writes and read back including the upper 64 KiB
        for (int i = 0; i < 150; i++) begin
            a     = wb_addr_t'($random(seed));
            a[17] = 1'b0;
            if (i % 4 == 0) a[16] = 1'b1;
            addr_list.push_back(a);
            wb_access(a, 1'b1, data_t'($random(seed)));
        end
        foreach (addr_list[i]) wb_access(addr_list[i], 1'b0, '0);

        // CPU slots read and write the shared window in between
        for (int i = 0; i < 32; i++) begin
            a = {10'h004, 8'($random(seed))};
            wb_access(a, 1'b1, data_t'($random(seed)));
        end
        repeat (100) @(posedge sys_clock);
        for (int i = 0; i < 128; i++) begin
            wb_access({10'h004, 8'(i * 2)}, 1'b0, '0);
        end
        repeat (4) @(posedge sys_clock);

        scoreboard.print_report();
        if (scoreboard.error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        scoreboard.print_report();
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bus_core_assertions.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus ownership assertions, bound into the bus core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bus_core_assertions (
    input  logic                        sys_clock_i,
    input  logic                        sys_reset_ni,
    input  logic                        cpu_be_i,
    input  bus_core_pkg::bridge_state_t bridge_state_i,
    input  logic                        bridge_ack_i,
    input  logic                        bridge_we_i,
    input  logic                        io_sel_i
);
    import bus_core_pkg::*;

    // CPU slot only opens once the bridge is idle or finishing
    cpu_owns_bus: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        cpu_be_i |-> (bridge_state_i == IDLE || bridge_ack_i))
        else $error("cpu_be_o high while the RAM bridge is busy");

    bridge_write_alone: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        bridge_we_i |-> !io_sel_i && !cpu_be_i)
        else $error("bridge RAM write overlaps an I/O select");

endmodule

bind bus_core bus_core_assertions ownership_checks (
    .sys_clock_i   (sys_clock_i),
    .sys_reset_ni  (sys_reset_ni),
    .cpu_be_i      (cpu_be_o),
    .bridge_state_i(ram_bridge.state_q),
    .bridge_ack_i  (ram_rsp.ack),
    .bridge_we_i   (bridge_we),
    .io_sel_i      (io_oe_o || pia1_cs_o || pia2_cs_o || via_cs_o)
);

`default_nettype wire

// ==== bus_core_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference decode, RAM and control shadows, error counting
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bus_core_checker #(
    parameter int unsigned SLOT_CYCLES = 4
) (
    input  logic                    sys_clock_i,
    input  logic                    sys_reset_ni,
    input  bus_core_pkg::cpu_addr_t cpu_addr_i,
    input  logic                    cpu_we_i,
    input  bus_core_pkg::data_t     cpu_data_i,
    input  logic                    cpu_be_i,
    input  logic                    cpu_clock_i,
    input  logic                    cpu_ready_i,
    input  logic                    cpu_reset_i,
    input  bus_core_pkg::wb_req_t   wb_req_i,
    input  bus_core_pkg::wb_rsp_t   wb_rsp_i,
    input  bus_core_pkg::data_t     ram_data_i,
    input  logic                    ram_oe_i,
    input  logic                    ram_we_i,
    input  logic                    io_oe_i,
    input  logic                    pia1_cs_i,
    input  logic                    pia2_cs_i,
    input  logic                    via_cs_i
);
    import bus_core_pkg::*;

    typedef struct packed {
        logic ram;
        logic io;
        logic pia1;
        logic pia2;
        logic via;
    } decode_t;

    data_t       shadow [0:(1 << RAM_ADDR_WIDTH)-1];
    logic        ctrl_ready;
    logic        ctrl_reset;
    int          error_count = 0;
    int          check_count = 0;
    logic        pend_valid;
    logic        pend_ram;
    logic        pend_we;
    data_t       pend_exp;
    int unsigned pend_cycle;
    int unsigned cycle;

    // PET map with the I/O page at E800-E8FF and chips on bits 4, 5 and 6
    function automatic decode_t expected_decode(input cpu_addr_t a);
        decode_t d;
        d.io   = (a >= 16'hE800) && (a <= 16'hE8FF);
        d.ram  = !d.io;
        d.pia1 = d.io && a[4];
        d.pia2 = d.io && a[5];
        d.via  = d.io && a[6];
        return d;
    endfunction

    function automatic data_t fill_byte(input ram_addr_t a);
        return a[7:0] ^ a[15:8] ^ {7'h2d, a[16]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        if (exp !== got) begin
            error_count++;
            $display("FAIL %s expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic print_report();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    initial begin
        for (int i = 0; i < (1 << RAM_ADDR_WIDTH); i++) begin
            shadow[i] = fill_byte(ram_addr_t'(i));
        end
    end

    always @(posedge sys_clock_i or negedge sys_reset_ni) begin
        decode_t     exp;
        ram_addr_t   ra;
        int unsigned pos;
        logic        cpu_slot;
        logic        slot_end;
        logic        wb_window;
        if (!sys_reset_ni) begin
            ctrl_ready = 1'b0;
            ctrl_reset = 1'b1;
            pend_valid = 1'b0;
            cycle      = 0;
        end else begin
            cycle++;
            // Registered phase outputs put the first CPU slot on cycle 2
            pos       = (cycle - 2) % (2 * SLOT_CYCLES);
            cpu_slot  = (cycle >= 2) && (pos < SLOT_CYCLES);
            slot_end  = cpu_slot && (pos == SLOT_CYCLES - 1);
            wb_window = (cycle >= 2) && (pos >= SLOT_CYCLES) && (pos <= 2 * SLOT_CYCLES - 3);

            check_value("cpu_be_o", cpu_slot, cpu_be_i);
            check_value("cpu_clock_o", cpu_slot, cpu_clock_i);
            check_value("cpu_ready_o", ctrl_ready, cpu_ready_i);
            check_value("cpu_reset_o", ctrl_reset, cpu_reset_i);

            exp = expected_decode(cpu_addr_i);
            check_value("io_oe_o", exp.io && cpu_slot, io_oe_i);
            check_value("pia1_cs_o", exp.pia1 && cpu_slot, pia1_cs_i);
            check_value("pia2_cs_o", exp.pia2 && cpu_slot, pia2_cs_i);
            check_value("via_cs_o", exp.via && cpu_slot, via_cs_i);
            if (cpu_slot) begin
                check_value("ram_oe_o", exp.ram && !cpu_we_i, ram_oe_i);
                check_value("ram_we_o", exp.ram && cpu_we_i && slot_end, ram_we_i);
                if (ram_oe_i) check_value("ram_data_i", shadow[{1'b0, cpu_addr_i}], ram_data_i);
                // CPU write lands at the end of its slot
                if (slot_end && cpu_we_i && exp.ram) begin
                    shadow[{1'b0, cpu_addr_i}] = cpu_data_i;
                end
            end
            if (wb_req_i.cycle && wb_req_i.strobe && !wb_window) begin
                check_value("wb_rsp_o.stall", 1'b1, wb_rsp_i.stall);
            end

            if (wb_rsp_i.ack) begin
                if (!pend_valid) begin
                    error_count++;
                    $display("Wishbone ack arrived with no request outstanding");
                end else begin
                    check_value("wb_rsp_o.ack latency", pend_ram ? 2 : 1, cycle - pend_cycle);
                    if (!pend_we) check_value("wb_rsp_o.data", pend_exp, wb_rsp_i.data);
                    pend_valid = 1'b0;
                end
            end

            if (wb_req_i.cycle && wb_req_i.strobe && !wb_rsp_i.stall) begin
                if (pend_valid) begin
                    error_count++;
                    $display("Wishbone request accepted while another was outstanding");
                end
                pend_valid = 1'b1;
                pend_cycle = cycle;
                pend_we    = wb_req_i.we;
                pend_ram   = !wb_req_i.addr[WB_ADDR_WIDTH-1];
                ra         = wb_req_i.addr[RAM_ADDR_WIDTH-1:0];
                if (pend_ram) begin
                    pend_exp = shadow[ra];
                    if (wb_req_i.we) shadow[ra] = wb_req_i.data;
                end else begin
                    pend_exp = {6'b0, ctrl_reset, ctrl_ready};
                    if (wb_req_i.we && ra == '0) begin
                        ctrl_ready = wb_req_i.data[0];
                        ctrl_reset = wb_req_i.data[1];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bus_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus core top with RAM pin mux and Wishbone response merge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bus_core #(
    parameter int unsigned SLOT_CYCLES = 4
) (
    input  logic                    sys_clock_i,
    input  logic                    sys_reset_ni,

    // CPU
    input  bus_core_pkg::cpu_addr_t cpu_addr_i,
    input  logic                    cpu_we_i,
    output logic                    cpu_be_o,
    output logic                    cpu_clock_o,
    output logic                    cpu_ready_o,
    output logic                    cpu_reset_o,

    // Host Wishbone port
    input  bus_core_pkg::wb_req_t   wb_req_i,
    output bus_core_pkg::wb_rsp_t   wb_rsp_o,

    // RAM and I/O
    input  bus_core_pkg::data_t     ram_data_i,
    output bus_core_pkg::ram_addr_t ram_addr_o,
    output bus_core_pkg::data_t     ram_data_o,
    output logic                    ram_data_oe_o,
    output logic                    ram_oe_o,
    output logic                    ram_we_o,
    output logic                    io_oe_o,
    output logic                    pia1_cs_o,
    output logic                    pia2_cs_o,
    output logic                    via_cs_o
);
    import bus_core_pkg::*;

    bus_phase_t phase;
    logic       reg_target;
    logic       ram_sel;
    logic       reg_sel;
    wb_rsp_t    ram_rsp;
    wb_rsp_t    reg_rsp;
    ram_addr_t  bridge_addr;
    logic       bridge_data_oe;
    logic       bridge_oe;
    logic       bridge_we;
    logic       ram_en;
    logic       io_en;
    logic       pia1_en;
    logic       pia2_en;
    logic       via_en;

    bus_timing #(
        .SLOT_CYCLES(SLOT_CYCLES)
    ) timing (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .phase_o     (phase)
    );

    // Targets only see a request inside the grant window
    assign reg_target = wb_req_i.addr[WB_REG_SEL_BIT];
    assign ram_sel    = phase.wb_grant && !reg_target;
    assign reg_sel    = phase.wb_grant && reg_target;

    wb_ram_bridge ram_bridge (
        .sys_clock_i  (sys_clock_i),
        .sys_reset_ni (sys_reset_ni),
        .wb_req_i     (wb_req_i),
        .wb_sel_i     (ram_sel),
        .wb_rsp_o     (ram_rsp),
        .ram_data_i   (ram_data_i),
        .ram_addr_o   (bridge_addr),
        .ram_data_o   (ram_data_o),     // Only driven onto the bus when data OE is set
        .ram_data_oe_o(bridge_data_oe),
        .ram_oe_o     (bridge_oe),
        .ram_we_o     (bridge_we)
    );

    register_file regs (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .wb_req_i    (wb_req_i),
        .wb_sel_i    (reg_sel),
        .wb_rsp_o    (reg_rsp),
        .cpu_ready_o (cpu_ready_o),
        .cpu_reset_o (cpu_reset_o)
    );

    address_decoder decoder (
        .addr_i   (cpu_addr_i),
        .ram_en_o (ram_en),
        .io_en_o  (io_en),
        .pia1_en_o(pia1_en),
        .pia2_en_o(pia2_en),
        .via_en_o (via_en)
    );

    // One request in flight, so at most one ack per cycle
    always_comb begin
        wb_rsp_o.ack   = ram_rsp.ack || reg_rsp.ack;
        wb_rsp_o.data  = ram_rsp.ack ? ram_rsp.data : reg_rsp.data;
        wb_rsp_o.stall = !phase.wb_grant || (reg_target ? reg_rsp.stall : ram_rsp.stall);
    end

    assign cpu_be_o    = phase.cpu_grant;
    assign cpu_clock_o = phase.cpu_clock;

    // RAM pins belong to the CPU in its slot, to the bridge otherwise
    always_comb begin
        if (cpu_be_o) begin
            ram_addr_o    = {1'b0, cpu_addr_i};     // CPU sees the low 64 KiB
            ram_oe_o      = ram_en && !cpu_we_i;
            ram_we_o      = ram_en && cpu_we_i && phase.cpu_done;
            ram_data_oe_o = 1'b0;                   // CPU drives the data bus
        end else begin
            ram_addr_o    = bridge_addr;
            ram_oe_o      = bridge_oe;
            ram_we_o      = bridge_we;
            ram_data_oe_o = bridge_data_oe;
        end
    end

    assign io_oe_o   = io_en && cpu_be_o;
    assign pia1_cs_o = pia1_en && cpu_be_o;
    assign pia2_cs_o = pia2_en && cpu_be_o;
    assign via_cs_o  = via_en && cpu_be_o;

endmodule

`default_nettype wire

// ==== address_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PET memory map decode of the CPU address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module address_decoder (
    input  bus_core_pkg::cpu_addr_t addr_i,
    output logic                    ram_en_o,
    output logic                    io_en_o,
    output logic                    pia1_en_o,
    output logic                    pia2_en_o,
    output logic                    via_en_o
);
    import bus_core_pkg::*;

    localparam int unsigned PAGE_BITS = 8;      // 256 byte pages

    // Whole I/O page is claimed, even unpopulated holes
    assign io_en_o = addr_i[CPU_ADDR_WIDTH-1:PAGE_BITS] == IO_BASE[CPU_ADDR_WIDTH-1:PAGE_BITS];

    // Everything outside the I/O page is RAM
    assign ram_en_o = !io_en_o;

    // Partial decode like the original board, so E830 hits both PIAs
    assign pia1_en_o = io_en_o && addr_i[PIA1_BIT];
    assign pia2_en_o = io_en_o && addr_i[PIA2_BIT];
    assign via_en_o  = io_en_o && addr_i[VIA_BIT];

endmodule

`default_nettype wire

// ==== register_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone control register for CPU reset and ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                  sys_clock_i,
    input  logic                  sys_reset_ni,
    input  bus_core_pkg::wb_req_t wb_req_i,
    input  logic                  wb_sel_i,
    output bus_core_pkg::wb_rsp_t wb_rsp_o,
    output logic                  cpu_ready_o,
    output logic                  cpu_reset_o
);
    import bus_core_pkg::*;

    logic  accept;
    logic  ctrl_hit;
    logic  ack_q;
    data_t rd_data_q;

    assign accept   = wb_sel_i && wb_req_i.cycle && wb_req_i.strobe;   // Never stalls
    assign ctrl_hit = wb_req_i.addr[WB_REG_SEL_BIT-1:0] == REG_CTRL_ADDR;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            ack_q       <= 1'b0;
            cpu_ready_o <= 1'b0;
            cpu_reset_o <= 1'b1;    // CPU held in reset until the host lets go
        end else begin
            ack_q <= accept;
            if (accept && wb_req_i.we && ctrl_hit) begin
                cpu_ready_o <= wb_req_i.data[CTRL_READY_BIT];
                cpu_reset_o <= wb_req_i.data[CTRL_RESET_BIT];
            end
        end
    end

    // Unmapped offsets read as zero
    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            rd_data_q <= '0;
            if (ctrl_hit) begin
                rd_data_q[CTRL_READY_BIT] <= cpu_ready_o;
                rd_data_q[CTRL_RESET_BIT] <= cpu_reset_o;
            end
        end
    end

    assign wb_rsp_o = '{
        data:  rd_data_q,
        stall: 1'b0,
        ack:   ack_q
    };

endmodule

`default_nettype wire

// ==== wb_ram_bridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone target running one RAM cycle per request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module wb_ram_bridge (
    input  logic                    sys_clock_i,
    input  logic                    sys_reset_ni,

    // Wishbone side
    input  bus_core_pkg::wb_req_t   wb_req_i,
    input  logic                    wb_sel_i,       // RAM addressed and grant active
    output bus_core_pkg::wb_rsp_t   wb_rsp_o,

    // RAM pins, muxed with the CPU at the top level
    input  bus_core_pkg::data_t     ram_data_i,
    output bus_core_pkg::ram_addr_t ram_addr_o,
    output bus_core_pkg::data_t     ram_data_o,
    output logic                    ram_data_oe_o,
    output logic                    ram_oe_o,
    output logic                    ram_we_o
);
    import bus_core_pkg::*;

    bridge_state_t state_q;
    ram_addr_t     addr_q;
    data_t         wr_data_q;
    data_t         rd_data_q;
    logic          we_q;
    logic          accept;

    assign accept = wb_sel_i && wb_req_i.cycle && wb_req_i.strobe && (state_q == IDLE);

    // IDLE -> DRIVE -> CAPTURE, ack lands two cycles after accept
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= DRIVE;
                    end
                end
                DRIVE:   state_q <= CAPTURE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            addr_q    <= wb_req_i.addr[RAM_ADDR_WIDTH-1:0];
            wr_data_q <= wb_req_i.data;
            we_q      <= wb_req_i.we;
        end
        // RAM output is valid by the end of the OE cycle
        if (state_q == DRIVE && !we_q) begin
            rd_data_q <= ram_data_i;
        end
    end

    assign ram_addr_o    = addr_q;
    assign ram_data_o    = wr_data_q;
    assign ram_oe_o      = (state_q == DRIVE) && !we_q;
    assign ram_we_o      = (state_q == DRIVE) && we_q;
    assign ram_data_oe_o = (state_q != IDLE) && we_q;   // Hold data one cycle past WE

    // Busy until the cycle completes
    assign wb_rsp_o = '{
        data:  rd_data_q,
        stall: state_q != IDLE,
        ack:   state_q == CAPTURE
    };

endmodule

`default_nettype wire

// ==== bus_timing.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot counter for CPU and Wishbone bus ownership
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module bus_timing #(
    parameter int unsigned SLOT_CYCLES = 4          // Minimum 3
) (
    input  logic                     sys_clock_i,
    input  logic                     sys_reset_ni,
    output bus_core_pkg::bus_phase_t phase_o
);
    import bus_core_pkg::*;

    localparam int unsigned PERIOD      = 2 * SLOT_CYCLES;
    localparam int unsigned COUNT_WIDTH = $clog2(PERIOD);
    // Last Wishbone cycle that may accept, so DRIVE and CAPTURE still fit
    localparam int unsigned WB_LAST     = PERIOD - 3;

    logic [COUNT_WIDTH-1:0] count_q;
    logic                   cpu_half;
    bus_phase_t             phase_next;

    assign cpu_half = count_q < COUNT_WIDTH'(SLOT_CYCLES);

    always_comb begin
        phase_next.cpu_grant = cpu_half;
        phase_next.cpu_clock = cpu_half;    // Phi2 high while the CPU owns the bus
        phase_next.cpu_done  = count_q == COUNT_WIDTH'(SLOT_CYCLES - 1);
        phase_next.wb_grant  = !cpu_half && (count_q <= COUNT_WIDTH'(WB_LAST));
    end

    // Outputs lag the counter by one cycle
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            count_q <= '0;                  // Start in the CPU half
            phase_o <= '0;
        end else begin
            phase_o <= phase_next;
            if (count_q == COUNT_WIDTH'(PERIOD - 1)) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bus_core_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths, PET memory map constants, Wishbone and phase types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package bus_core_pkg;

    localparam int unsigned CPU_ADDR_WIDTH = 16;
    localparam int unsigned RAM_ADDR_WIDTH = 17;    // 128 KiB
    localparam int unsigned WB_ADDR_WIDTH  = 18;
    localparam int unsigned DATA_WIDTH     = 8;

    typedef logic [CPU_ADDR_WIDTH-1:0] cpu_addr_t;
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [WB_ADDR_WIDTH-1:0]  wb_addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;

    // Top Wishbone address bit picks the register file, clear means RAM
    localparam int unsigned WB_REG_SEL_BIT = WB_ADDR_WIDTH - 1;

    // I/O page E800-E8FF, chips selected by single address bits
    localparam cpu_addr_t   IO_BASE  = 16'hE800;
    localparam int unsigned PIA1_BIT = 4;           // E810
    localparam int unsigned PIA2_BIT = 5;           // E820
    localparam int unsigned VIA_BIT  = 6;           // E840

    localparam logic [WB_REG_SEL_BIT-1:0] REG_CTRL_ADDR = '0;
    localparam int unsigned CTRL_READY_BIT = 0;
    localparam int unsigned CTRL_RESET_BIT = 1;

    typedef struct packed {
        wb_addr_t addr;
        data_t    data;
        logic     we;
        logic     cycle;
        logic     strobe;
    } wb_req_t;

    typedef struct packed {
        data_t data;
        logic  stall;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        logic cpu_grant;
        logic wb_grant;
        logic cpu_clock;
        logic cpu_done;     // Last cycle of the CPU slot
    } bus_phase_t;

    typedef enum logic [1:0] {
        IDLE,
        DRIVE,
        CAPTURE
    } bridge_state_t;

endpackage

`default_nettype wire
